/* source/lcd_i2c_pkg.sv */
package lcd_i2c_pkg;

    // Display effect requested by the host
    typedef enum logic [1:0] {
        EFF_NONE   = 2'd0,
        EFF_BLINK  = 2'd1,
        EFF_SCROLL = 2'd2,
        EFF_CLEAR  = 2'd3
    } effect_e;

    // Bit engine FSM states
    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,
        ST_START = 3'd1,
        ST_SEND  = 3'd2,
        ST_ACK   = 3'd3,
        ST_STOP  = 3'd4
    } eng_state_e;

    // One byte offered from the sequencer to the bit engine
    typedef struct packed {
        logic       load;  // One-cycle offer strobe
        logic       last;  // Final byte of the frame
        logic [7:0] data;
    } byte_req_t;

    // Pins of the I2C bus as driven by the engine
    typedef struct packed {
        logic scl;
        logic sda;     // Driven value
        logic sda_oe;  // High while the master owns SDA
    } bus_pins_t;

    // LCD control byte for each effect
    function automatic logic [7:0] ctrl_byte_of(input effect_e eff);
        case (eff)
            EFF_BLINK: begin
                return 8'h0D;  // Display on, cursor blink
            end
            EFF_SCROLL: begin
                return 8'h18;  // Shift display left
            end
            EFF_CLEAR: begin
                return 8'h01;  // Clear display
            end
            default: begin
                return 8'h80;  // DDRAM address 0
            end
        endcase
    endfunction

endpackage

/* source/tick_gen.sv */
`timescale 1ns/1ps

module tick_gen #(
    parameter int unsigned TICK_DIV = 128
) (
    input  logic clk,
    input  logic rst,
    output logic tick_o
);

    localparam int unsigned CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [CNT_W-1:0] cnt;

    // Free-running, never restarted by a frame
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt    <= '0;
            tick_o <= 1'b0;
        end else begin
            if (cnt == CNT_W'(TICK_DIV - 1)) begin
                cnt    <= '0;
                tick_o <= 1'b1;  // Pulse on wrap
            end else begin
                cnt    <= cnt + 1'b1;
                tick_o <= 1'b0;
            end
        end
    end

endmodule

/* source/frame_sequencer.sv */
`timescale 1ns/1ps

module frame_sequencer
    import lcd_i2c_pkg::*;
#(
    parameter logic [6:0] LCD_ADDR = 7'h27
) (
    input  logic       clk,
    input  logic       rst,
    input  effect_e    effect_i,
    input  logic [7:0] lcd_data_i,
    input  logic       engine_busy_i,
    input  logic       byte_done_i,
    input  logic       ack_ok_i,
    output byte_req_t  req_o,
    output logic       nack_o
);

    // Address, control, data
    localparam int unsigned BYTES_PER_FRAME = 3;
    localparam logic [1:0]  LAST_IDX        = 2'(BYTES_PER_FRAME - 1);

    effect_e    eff_q;      // Last effect sent
    logic [7:0] data_q;     // Data byte latched at frame start
    logic [1:0] byte_idx;   // Byte currently offered or in flight
    logic       next_load;  // Offer of the following byte
    logic       start;

    // A new frame only begins with the engine idle, so a change
    // seen during a frame waits here until STOP completes
    assign start = !engine_busy_i && (effect_i != eff_q);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            eff_q     <= EFF_NONE;
            byte_idx  <= '0;
            next_load <= 1'b0;
            nack_o    <= 1'b0;
        end else begin
            next_load <= 1'b0;
            nack_o    <= byte_done_i && !ack_ok_i;  // Frame abandoned
            if (start) begin
                eff_q    <= effect_i;  // Updated even if later NACKed
                byte_idx <= '0;
            end else if (byte_done_i) begin
                if (ack_ok_i && (byte_idx != LAST_IDX)) begin
                    byte_idx  <= byte_idx + 2'd1;
                    next_load <= 1'b1;
                end else begin
                    byte_idx <= '0;  // Last byte or NACK ends the frame
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            data_q <= lcd_data_i;  // Later changes do not touch this frame
        end
    end

    // The request is decoded from the byte index, so the address byte
    // is ready in the same cycle as the start decision
    always_comb begin
        case (byte_idx)
            2'd0: begin
                req_o.data = {LCD_ADDR, 1'b0};  // Write
            end
            2'd1: begin
                req_o.data = ctrl_byte_of(eff_q);
            end
            default: begin
                req_o.data = data_q;
            end
        endcase
        req_o.load = start | next_load;
        req_o.last = (byte_idx == LAST_IDX);
    end

endmodule

/* source/bit_engine.sv */
`timescale 1ns/1ps

module bit_engine
    import lcd_i2c_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      tick_i,
    input  byte_req_t req_i,
    input  logic      sda_i,
    output bus_pins_t pins_o,
    output logic      busy_o,
    output logic      byte_done_o,
    output logic      ack_ok_o
);

    eng_state_e state;
    logic [1:0] phase;    // Quarter of the current bit
    logic [2:0] bit_idx;  // Bits left in the byte
    logic [7:0] shift_q;  // MSB on the bus
    logic       last_q;
    logic       ack_q;

    logic       phase_end;

    // Every state lasts a whole number of 4-tick bits
    assign phase_end = tick_i && (phase == 2'd3);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= ST_IDLE;
            phase       <= '0;
            bit_idx     <= '0;
            last_q      <= 1'b0;
            ack_q       <= 1'b0;
            byte_done_o <= 1'b0;
            ack_ok_o    <= 1'b0;
        end else begin
            byte_done_o <= 1'b0;
            if (req_i.load) begin
                last_q <= req_i.last;
            end
            if (state == ST_IDLE) begin
                if (req_i.load) begin
                    state <= ST_START;
                    phase <= '0;
                end
            end else if (tick_i) begin
                phase <= phase + 2'd1;  // Wraps to 0 at each bit boundary
                case (state)
                    ST_START: begin
                        if (phase_end) begin
                            state   <= ST_SEND;
                            bit_idx <= 3'd7;
                        end
                    end
                    ST_SEND: begin
                        if (phase_end) begin
                            bit_idx <= bit_idx - 3'd1;
                            if (bit_idx == 3'd0) begin
                                state <= ST_ACK;
                            end
                        end
                    end
                    ST_ACK: begin
                        if (phase == 2'd2) begin
                            ack_q <= !sda_i;  // Last high quarter, low is ACK
                        end
                        if (phase_end) begin
                            byte_done_o <= 1'b1;
                            ack_ok_o    <= ack_q;
                            if (!ack_q || last_q) begin
                                state <= ST_STOP;  // NACK skips remaining bytes
                            end else begin
                                state   <= ST_SEND;  // Next byte loads meanwhile
                                bit_idx <= 3'd7;
                            end
                        end
                    end
                    ST_STOP: begin
                        if (phase_end) begin
                            state <= ST_IDLE;
                        end
                    end
                    default: begin
                        state <= ST_IDLE;
                    end
                endcase
            end
        end
    end

    // Shift register, new bit appears while SCL is low
    always_ff @(posedge clk) begin
        if (req_i.load) begin
            shift_q <= req_i.data;
        end else if (phase_end && (state == ST_SEND)) begin
            shift_q <= {shift_q[6:0], 1'b0};
        end
    end

    // Pin levels per state and quarter
    // A data or ACK bit has SCL high in quarters 1 and 2
    always_comb begin
        pins_o.scl    = 1'b1;
        pins_o.sda    = 1'b1;
        pins_o.sda_oe = 1'b1;
        case (state)
            ST_START: begin
                pins_o.scl = (phase != 2'd3);
                pins_o.sda = (phase == 2'd0);  // Falls with SCL high
            end
            ST_SEND: begin
                pins_o.scl = (phase == 2'd1) || (phase == 2'd2);
                pins_o.sda = shift_q[7];
            end
            ST_ACK: begin
                pins_o.scl    = (phase == 2'd1) || (phase == 2'd2);
                pins_o.sda_oe = 1'b0;  // Slave owns SDA
            end
            ST_STOP: begin
                pins_o.scl = (phase != 2'd0);
                pins_o.sda = phase[1];  // Rises with SCL high
            end
            default: begin
                pins_o.scl = 1'b1;  // Bus idle-high
            end
        endcase
    end

    assign busy_o = (state != ST_IDLE);

endmodule

/* source/lcd_i2c_top.sv */
`timescale 1ns/1ps

module lcd_i2c_top
    import lcd_i2c_pkg::*;
#(
    parameter int unsigned TICK_DIV = 128,
    parameter logic [6:0]  LCD_ADDR = 7'h27
) (
    input  logic       clk,
    input  logic       rst,
    input  effect_e    effect_i,
    input  logic [7:0] lcd_data_i,
    input  logic       sda_i,
    output logic       scl_o,
    output logic       sda_o,
    output logic       sda_oe_o,
    output logic       busy_o,
    output logic       nack_o
);

    logic      tick;
    byte_req_t req;
    logic      byte_done;
    logic      ack_ok;
    bus_pins_t pins;

    tick_gen #(
        .TICK_DIV (TICK_DIV)
    ) u_tick_gen (
        .clk    (clk),
        .rst    (rst),
        .tick_o (tick)
    );

    frame_sequencer #(
        .LCD_ADDR (LCD_ADDR)
    ) u_frame_sequencer (
        .clk           (clk),
        .rst           (rst),
        .effect_i      (effect_i),
        .lcd_data_i    (lcd_data_i),
        .engine_busy_i (busy_o),
        .byte_done_i   (byte_done),
        .ack_ok_i      (ack_ok),
        .req_o         (req),
        .nack_o        (nack_o)
    );

    bit_engine u_bit_engine (
        .clk         (clk),
        .rst         (rst),
        .tick_i      (tick),
        .req_i       (req),
        .sda_i       (sda_i),
        .pins_o      (pins),
        .busy_o      (busy_o),
        .byte_done_o (byte_done),
        .ack_ok_o    (ack_ok)
    );

    // Pad is open drain on the board
    assign scl_o    = pins.scl;
    assign sda_o    = pins.sda;
    assign sda_oe_o = pins.sda_oe;

endmodule

/* tb/lcd_i2c_properties.sv */
`timescale 1ns/1ps

module lcd_i2c_properties
    import lcd_i2c_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input eng_state_e state_i,
    input bus_pins_t  pins_i,
    input logic       busy_i,
    input logic       byte_done_i
);

    bit violated;  // Set by any failing assertion and never cleared

    // Bus idle-high as soon as reset is released
    assert property (@(posedge clk)
        $fell(rst) |-> pins_i.scl && pins_i.sda && pins_i.sda_oe && !busy_i)
    else begin
        $error("Bus not idle-high after reset");
        violated = 1'b1;
    end

    // SDA may only move under a high SCL for START and STOP
    assert property (@(posedge clk) disable iff (rst)
        (pins_i.scl && $past(pins_i.scl) && (pins_i.sda != $past(pins_i.sda)))
        |-> (state_i inside {ST_START, ST_STOP}))
    else begin
        $error("SDA changed while SCL high in state %s", state_i.name());
        violated = 1'b1;
    end

    // SDA changes owner between master and slave only while SCL is low
    assert property (@(posedge clk) disable iff (rst)
        $changed(pins_i.sda_oe) |-> !pins_i.scl && !$past(pins_i.scl))
    else begin
        $error("SDA drive enable changed while SCL high");
        violated = 1'b1;
    end

    assert property (@(posedge clk) disable iff (rst) byte_done_i |=> !byte_done_i)
    else begin
        $error("byte_done wider than one cycle");
        violated = 1'b1;
    end

endmodule

bind bit_engine lcd_i2c_properties u_props (
    .clk         (clk),
    .rst         (rst),
    .state_i     (state),
    .pins_i      (pins_o),
    .busy_i      (busy_o),
    .byte_done_i (byte_done_o)
);

/* tb/lcd_i2c_tb.sv */
`timescale 1ns/1ps

module lcd_i2c_tb
    import lcd_i2c_pkg::*;
();

    localparam int unsigned TICK_DIV       = 4;
    localparam logic [6:0]  LCD_ADDR       = 7'h27;
    localparam int          FRAME_TICKS    = 116;
    localparam int          TIMEOUT_CYCLES = 8 * FRAME_TICKS * TICK_DIV * 2;
    localparam logic [31:0] SEED           = 32'hf407671d;

    logic       clk = 1'b0;
    logic       rst;
    effect_e    effect_i;
    logic [7:0] lcd_data_i;
    logic       scl_o, sda_o, sda_oe_o, busy_o, nack_o;
    logic       sda_bus;
    logic       slave_drive = 1'b1;  // Released unless acknowledging
    logic       nack_mode;

    logic       prev_scl = 1'b1;
    logic       prev_sda = 1'b1;
    logic [7:0] shreg    = 8'h00;
    logic [7:0] rx_byte;
    int         bit_cnt     = 0;
    int         byte_cnt    = 0;
    int         frame_bytes = 0;
    int         start_cnt   = 0;
    int         stop_cnt    = 0;
    int         nack_cnt    = 0;
    int         cycle_cnt   = 0;
    int         exp_starts  = 0;

    logic [7:0]  exp_bytes [3];
    logic [7:0]  cur_data;
    logic [31:0] seed;
    string       test_name;

    lcd_i2c_top #(
        .TICK_DIV (TICK_DIV),
        .LCD_ADDR (LCD_ADDR)
    ) UUT (
        .clk        (clk),
        .rst        (rst),
        .effect_i   (effect_i),
        .lcd_data_i (lcd_data_i),
        .sda_i      (sda_bus),
        .scl_o      (scl_o),
        .sda_o      (sda_o),
        .sda_oe_o   (sda_oe_o),
        .busy_o     (busy_o),
        .nack_o     (nack_o)
    );

    assign sda_bus = sda_oe_o ? sda_o : slave_drive;  // Open-drain bus

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // LCD control byte expected for each effect
    function automatic logic [7:0] ctrl_for_effect(input effect_e eff);
        case (eff)
            EFF_BLINK:  return 8'h0D;
            EFF_SCROLL: return 8'h18;
            EFF_CLEAR:  return 8'h01;
            default:    return 8'h80;
        endcase
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic wait_busy(input logic level);
        @(posedge clk);
        while (busy_o !== level) begin
            @(posedge clk);
        end
    endtask

    // New effect with a fresh data byte, and the frame it must produce
    task automatic request_effect(input effect_e eff, input string name);
        seed         = lcg_step(seed);
        cur_data     = seed[15:8];
        exp_bytes[0] = {LCD_ADDR, 1'b0};
        exp_bytes[1] = ctrl_for_effect(eff);
        exp_bytes[2] = cur_data;
        test_name    = name;
        effect_i   <= eff;
        lcd_data_i <= cur_data;
    endtask

    // Always differs from the byte already latched
    task automatic scramble_data();
        seed     = lcg_step(seed);
        cur_data = cur_data ^ (seed[7:0] | 8'h01);
        lcd_data_i <= cur_data;
    endtask

    task automatic check_frame_end(input int n_bytes);
        exp_starts++;
        assert (start_cnt == exp_starts) else report_failure($sformatf(
            "Mismatch in %s: starts expected %0d actual %0d", test_name, exp_starts, start_cnt));
        assert (stop_cnt == exp_starts) else report_failure($sformatf(
            "Mismatch in %s: stops expected %0d actual %0d", test_name, exp_starts, stop_cnt));
        assert (frame_bytes == n_bytes) else report_failure($sformatf(
            "Mismatch in %s: bytes expected %0d actual %0d", test_name, n_bytes, frame_bytes));
    endtask

    task automatic send_frame(input effect_e eff, input string name);
        request_effect(eff, name);
        wait_busy(1'b1);
        scramble_data();
        wait_busy(1'b0);
        check_frame_end(3);
    endtask

    // I2C slave, works on bus levels sampled at the clock edge
    always @(posedge clk) begin
        prev_scl <= scl_o;
        prev_sda <= sda_bus;
        if (prev_scl && scl_o && prev_sda && !sda_bus) begin
            start_cnt <= start_cnt + 1;
            bit_cnt   <= 0;
            byte_cnt  <= 0;
        end else if (prev_scl && scl_o && !prev_sda && sda_bus) begin
            stop_cnt    <= stop_cnt + 1;
            frame_bytes <= byte_cnt;
        end else if (!prev_scl && scl_o) begin
            if (bit_cnt < 8) begin
                rx_byte = {shreg[6:0], sda_bus};
                shreg   <= rx_byte;
                bit_cnt <= bit_cnt + 1;
                if (bit_cnt == 7) begin
                    assert (byte_cnt < 3) else report_failure("More than three bytes in a frame");
                    assert (rx_byte == exp_bytes[byte_cnt]) else report_failure($sformatf(
                        "Mismatch in %s: byte %0d expected %02h actual %02h",
                        test_name, byte_cnt, exp_bytes[byte_cnt], rx_byte));
                    byte_cnt <= byte_cnt + 1;
                end
            end else begin
                bit_cnt <= 9;  // Acknowledge clock
            end
        end else if (prev_scl && !scl_o) begin
            if (bit_cnt == 8) begin
                slave_drive <= nack_mode;  // Low is ACK
            end else if (bit_cnt == 9) begin
                slave_drive <= 1'b1;
                bit_cnt     <= 0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (nack_o) begin
            nack_cnt <= nack_cnt + 1;
        end
        if (UUT.u_bit_engine.u_props.violated) begin
            report_failure("Protocol assertion failed in the bit engine");
        end
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            report_failure("Timeout, the DUT did not finish the tests in time");
        end
    end

    initial begin
        rst        = 1'b1;
        effect_i   = EFF_NONE;
        lcd_data_i = 8'h00;
        nack_mode  = 1'b0;
        seed       = SEED;
        test_name  = "reset_idle";
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        repeat (100) @(posedge clk);
        assert (scl_o && sda_o && sda_oe_o && !busy_o && !nack_o)
            else report_failure("Bus not idle or outputs active after reset");
        assert (start_cnt == 0) else report_failure("START seen without an effect change");

        send_frame(EFF_BLINK, "blink");
        send_frame(EFF_SCROLL, "scroll");
        send_frame(EFF_CLEAR, "clear");
        assert (nack_cnt == 0) else report_failure("nack_o pulsed on acknowledged frames");

        // Address byte refused
        nack_mode <= 1'b1;
        request_effect(EFF_BLINK, "nack_address");
        wait_busy(1'b1);
        wait_busy(1'b0);
        check_frame_end(1);
        assert (nack_cnt == 1) else report_failure($sformatf(
            "Mismatch in %s: nack pulses expected 1 actual %0d", test_name, nack_cnt));
        nack_mode <= 1'b0;
        repeat (300) @(posedge clk);
        assert (start_cnt == exp_starts) else report_failure("Frame repeated after a NACK");

        // Two changes inside one frame
        request_effect(EFF_SCROLL, "double_change");
        wait_busy(1'b1);
        repeat (20) @(posedge clk);
        effect_i <= EFF_CLEAR;
        scramble_data();
        repeat (20) @(posedge clk);
        effect_i <= EFF_BLINK;
        wait_busy(1'b0);
        check_frame_end(3);
        exp_bytes[1] = ctrl_for_effect(EFF_BLINK);  // Only the final effect is sent
        exp_bytes[2] = cur_data;
        test_name    = "double_change_final";
        wait_busy(1'b1);
        wait_busy(1'b0);
        check_frame_end(3);
        repeat (300) @(posedge clk);
        assert (start_cnt == exp_starts) else report_failure("Extra frame after the double change");

        if (!UUT.u_bit_engine.u_props.violated) begin
            $display("Everything OK");
            $finish;
        end else begin
            report_failure("Protocol assertion failed in the bit engine");
        end
    end

endmodule

/* sources.f */
source/lcd_i2c_pkg.sv
source/tick_gen.sv
source/frame_sequencer.sv
source/bit_engine.sv
source/lcd_i2c_top.sv
tb/lcd_i2c_properties.sv
tb/lcd_i2c_tb.sv

/* Bender.yml */
package:
  name: lcd_i2c

dependencies: {}

sources:
  # Package first, then the pipeline stages and the top level
  - source/lcd_i2c_pkg.sv
  - source/tick_gen.sv
  - source/frame_sequencer.sv
  - source/bit_engine.sv
  - source/lcd_i2c_top.sv

  - target: test
    files:
      - tb/lcd_i2c_properties.sv
      - tb/lcd_i2c_tb.sv
